// File: filelist.f
src/isa_pkg.sv
src/trace_pkg.sv
src/trace_encoder.sv
src/pc_queue.sv
src/retire_arbiter.sv
src/commit_tracer.sv
sim/tb_clock_gen.sv
sim/tb_commit_tracer.sv

// File: Bender.yml
package:
  name: commit_tracer

sources:
  - files:
      - src/isa_pkg.sv
      - src/trace_pkg.sv
      - src/trace_encoder.sv
      - src/pc_queue.sv
      - src/retire_arbiter.sv
      - src/commit_tracer.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_commit_tracer.sv

// File: sim/tb_commit_tracer.sv
// Commit tracer testbench
`timescale 1ns/1ns

module tb_commit_tracer import isa_pkg::*, trace_pkg::*; ();

  localparam int RandCycles  = 200;
  localparam int BurstLen    = 6;
  localparam int FloodCycles = 40;
  // Phases plus drain and reset time come to about 400 cycles
  localparam int TestCycles  = 400;
  localparam int CycleLimit  = 5 * TestCycles;

  logic                              clk;
  logic                              rst_n;
  logic                              rst_req;
  commit_entry_t [NrCommitPorts-1:0] commit_instr;
  commit_entry_t [NrCommitPorts-1:0] prev_instr;
  logic          [NrCommitPorts-1:0] commit_ack;
  logic          [NrCommitPorts-1:0] prev_ack;
  priv_lvl_t                         priv_lvl;
  logic                              debug_mode;
  trace_mode_t                       prev_mode;
  trace_entry_t  [NrCommitPorts-1:0] trace;
  logic                              pc_valid;
  vaddr_t                            pc;
  port_idx_t                         pc_port;
  logic          [NrCommitPorts-1:0] overflow;

  // Reference model of pending PCs per port
  vaddr_t      exp_q [NrCommitPorts][$];
  port_idx_t   burst_ports [$];
  logic        lossy;
  logic        collect;
  logic [29:0] seq;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  tb_clock_gen i_clock_gen (
    .rst_req_i ( rst_req ),
    .clk_o     ( clk     ),
    .rst_no    ( rst_n   )
  );

  commit_tracer uut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .commit_instr_i ( commit_instr ),
    .commit_ack_i   ( commit_ack   ),
    .priv_lvl_i     ( priv_lvl     ),
    .debug_mode_i   ( debug_mode   ),
    .trace_o        ( trace        ),
    .pc_valid_o     ( pc_valid     ),
    .pc_o           ( pc           ),
    .pc_port_o      ( pc_port      ),
    .overflow_o     ( overflow     )
  );

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("[ERROR] %0t ns: %s", $time, msg);
    end
  endtask

  function automatic logic any_flag(input trace_entry_t [NrCommitPorts-1:0] t);
    logic found;
    found = 1'b0;
    for (int i = 0; i < NrCommitPorts; i++) begin
      found |= t[i].valid | t[i].exception | t[i].interrupt;
    end
    return found;
  endfunction

  // A cycle without acknowledge leaves no flag in the next record
  assert property (@(posedge clk) disable iff (!rst_n) (commit_ack == '0) |=> !any_flag(trace))
    else begin
      errors++;
      $display("[ERROR] %0t ns: trace flag set after a cycle without acknowledge", $time);
    end

  function automatic trace_mode_t expected_mode(input logic dbg, input priv_lvl_t priv);
    if (dbg) begin
      return ModeD;
    end
    case (priv)
      PrivU:   return ModeU;
      PrivS:   return ModeS;
      default: return ModeM;
    endcase
  endfunction

  function automatic priv_lvl_t priv_from_index(input int n);
    case (n)
      0:       return PrivU;
      1:       return PrivS;
      default: return PrivM;
    endcase
  endfunction

  task automatic check_trace();
    logic trapped;
    logic irq;
    for (int i = 0; i < NrCommitPorts; i++) begin
      trapped = prev_ack[i] & prev_instr[i].ex.valid;
      irq     = prev_instr[i].ex.cause[CauseIrqBit];
      check_value($sformatf("trace_o[%0d].valid", i),
                  64'(prev_ack[i] & ~prev_instr[i].ex.valid), 64'(trace[i].valid));
      check_value($sformatf("trace_o[%0d].exception", i),
                  64'(trapped & ~irq), 64'(trace[i].exception));
      check_value($sformatf("trace_o[%0d].interrupt", i),
                  64'(trapped & irq), 64'(trace[i].interrupt));
      if (prev_ack[i]) begin
        check_value($sformatf("trace_o[%0d].iaddr", i), prev_instr[i].pc, trace[i].iaddr);
        check_value($sformatf("trace_o[%0d].cause", i), prev_instr[i].ex.cause, trace[i].cause);
        check_value($sformatf("trace_o[%0d].tval", i),
                    64'(prev_instr[i].ex.tval[31:0]), 64'(trace[i].tval));
        check_value($sformatf("trace_o[%0d].insn", i),
                    64'(prev_instr[i].ex.tval[31:0]), 64'(trace[i].insn));
        check_value($sformatf("trace_o[%0d].mode", i), 64'(prev_mode), 64'(trace[i].mode));
      end
    end
  endtask

  task automatic check_pc_stream();
    int port;
    int idx;
    if (pc_valid) begin
      port = int'(pc_port);
      idx  = -1;
      if (collect) begin
        burst_ports.push_back(pc_port);
      end
      if (exp_q[port].size() == 0) begin
        check_true(1'b0, $sformatf("pc_o %h on port %0d with no PC pending", pc, port));
      end else if (!lossy) begin
        check_value("pc_o", exp_q[port].pop_front(), pc);
      end else begin
        // Dropped pushes leave gaps but order must still hold
        for (int k = 0; k < exp_q[port].size(); k++) begin
          if (idx < 0 && exp_q[port][k] == pc) begin
            idx = k;
          end
        end
        check_true(idx >= 0, $sformatf("pc_o %h out of order for port %0d", pc, port));
        for (int k = 0; k <= idx; k++) begin
          void'(exp_q[port].pop_front());
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic drive(input logic [NrCommitPorts-1:0] ack, input int exc_pct,
                       input priv_lvl_t priv, input logic dbg);
    @(negedge clk);
    check_trace();
    check_pc_stream();
    for (int i = 0; i < NrCommitPorts; i++) begin
      commit_instr[i].pc       = {32'($urandom()), seq, 2'b00};
      commit_instr[i].ex.valid = ($urandom_range(99) < exc_pct);
      commit_instr[i].ex.cause = {32'($urandom()), 32'($urandom())};
      commit_instr[i].ex.tval  = {32'($urandom()), 32'($urandom())};
      seq++;
      if (ack[i] && !commit_instr[i].ex.valid) begin
        exp_q[i].push_back(commit_instr[i].pc);
      end
    end
    commit_ack = ack;
    priv_lvl   = priv;
    debug_mode = dbg;
    prev_instr = commit_instr;
    prev_ack   = ack;
    prev_mode  = expected_mode(dbg, priv);
  endtask

  // Idle until the PC stream has been quiet for a while
  task automatic drain();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      drive('0, 0, PrivM, 1'b0);
      quiet = pc_valid ? 0 : quiet + 1;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    check_trace();
    check_pc_stream();
    rst_req    = 1'b1;
    commit_ack = '0;
    prev_ack   = '0;
    lossy      = 1'b0;
    for (int i = 0; i < NrCommitPorts; i++) begin
      exp_q[i].delete();
    end
    repeat (3) drive('0, 0, PrivM, 1'b0);
    rst_req = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [NrCommitPorts-1:0] ack;
    void'($urandom(70280));
    rst_req      = 1'b0;
    commit_instr = '0;
    commit_ack   = '0;
    priv_lvl     = PrivM;
    debug_mode   = 1'b0;
    prev_instr   = '0;
    prev_ack     = '0;
    prev_mode    = ModeM;
    lossy        = 1'b0;
    collect      = 1'b0;
    seq          = '0;
    wait (rst_n === 1'b1);
    check_true(!pc_valid && overflow == '0, "PC stream or overflow active after reset");

    // Classification with every mode
    repeat (2) begin
      for (int d = 0; d < 2; d++) begin
        for (int p = 0; p < 3; p++) begin
          drive('1, 50, priv_from_index(p), 1'(d));
        end
      end
    end
    drive('0, 0, PrivM, 1'b0);

    // Random retirements at low rate
    for (int n = 0; n < RandCycles; n++) begin
      for (int i = 0; i < NrCommitPorts; i++) begin
        ack[i] = ($urandom_range(3) == 0);
      end
      drive(ack, 25, priv_from_index($urandom_range(2)), $urandom_range(7) == 0);
    end
    drain();
    for (int i = 0; i < NrCommitPorts; i++) begin
      check_true(exp_q[i].size() == 0, $sformatf("PCs of port %0d never reached pc_o", i));
    end
    check_value("overflow_o", '0, 64'(overflow));

    // Round-robin burst
    burst_ports.delete();
    collect = 1'b1;
    repeat (BurstLen) drive('1, 0, PrivU, 1'b0);
    drain();
    collect = 1'b0;
    check_true(burst_ports.size() == NrCommitPorts * BurstLen, "burst lost PCs");
    for (int k = 1; k < burst_ports.size(); k++) begin
      check_value("pc_port_o", 64'((int'(burst_ports[k-1]) + 1) % NrCommitPorts),
                  64'(burst_ports[k]));
    end

    // Flood both queues past their depth
    lossy = 1'b1;
    repeat (FloodCycles) drive('1, 0, PrivM, 1'b0);
    drive('0, 0, PrivM, 1'b0);
    check_true(overflow != '0, "overflow_o still clear after flooding both queues");
    drain();

    // Mid-run reset with entries in flight
    repeat (5) drive('1, 0, PrivS, 1'b0);
    apply_reset();
    check_value("overflow_o", '0, 64'(overflow));
    repeat (8) begin
      drive('0, 0, PrivM, 1'b0);
      check_true(!pc_valid, "pc_valid_o high after reset without a retirement");
    end
    drive(2'b10, 0, PrivM, 1'b0);
    drain();
    check_true(exp_q[1].size() == 0, "PC retired after reset never reached pc_o");

    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 3
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  logic por_n;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Power-on reset released on a falling edge
  initial begin
    por_n = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    por_n = 1'b1;
  end

  assign rst_no = por_n & ~rst_req_i;

endmodule

// File: src/commit_tracer.sv
// Commit trace and PC stream top level
`timescale 1ns/1ns

module commit_tracer import isa_pkg::*, trace_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  commit_entry_t [NrCommitPorts-1:0]  commit_instr_i,
  input  logic          [NrCommitPorts-1:0]  commit_ack_i,
  input  priv_lvl_t                          priv_lvl_i,
  input  logic                               debug_mode_i,
  output trace_entry_t  [NrCommitPorts-1:0]  trace_o,
  output logic                               pc_valid_o,
  output vaddr_t                             pc_o,
  output port_idx_t                          pc_port_o,
  output logic          [NrCommitPorts-1:0]  overflow_o
);

  // Queue status towards the arbiter
  vaddr_t [NrCommitPorts-1:0] queue_head;
  logic   [NrCommitPorts-1:0] queue_empty;
  logic   [NrCommitPorts-1:0] queue_pop;

  // --------------------------------------------------
  // Trace port
  // --------------------------------------------------
  trace_encoder i_trace_encoder (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .trace_o        ( trace_o        )
  );

  // --------------------------------------------------
  // PC queues, one per commit port
  // --------------------------------------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_pc_queue
    pc_queue #(
      .Depth ( PcQueueDepth )
    ) i_pc_queue (
      .clk_i      ( clk_i             ),
      .rst_ni     ( rst_ni            ),
      .commit_i   ( commit_instr_i[i] ),
      .ack_i      ( commit_ack_i[i]   ),
      .pop_i      ( queue_pop[i]      ),
      .head_o     ( queue_head[i]     ),
      .empty_o    ( queue_empty[i]    ),
      .overflow_o ( overflow_o[i]     )
    );
  end

  // --------------------------------------------------
  // Merged PC stream
  // --------------------------------------------------
  retire_arbiter i_retire_arbiter (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .head_i     ( queue_head  ),
    .empty_i    ( queue_empty ),
    .pop_o      ( queue_pop   ),
    .pc_valid_o ( pc_valid_o  ),
    .pc_o       ( pc_o        ),
    .pc_port_o  ( pc_port_o   )
  );

endmodule

// File: src/retire_arbiter.sv
// Round-robin PC stream merge
`timescale 1ns/1ns

module retire_arbiter import isa_pkg::*, trace_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  vaddr_t [NrCommitPorts-1:0]  head_i,
  input  logic   [NrCommitPorts-1:0]  empty_i,
  output logic   [NrCommitPorts-1:0]  pop_o,
  output logic                        pc_valid_o,
  output vaddr_t                      pc_o,
  output port_idx_t                   pc_port_o
);

  port_idx_t prio_q;
  port_idx_t prio_d;
  port_idx_t grant_idx;
  logic      grant_valid;
  logic      pc_valid_q;
  vaddr_t    pc_q;
  port_idx_t port_q;

  // --------------------------------------------------
  // Grant search starting at the priority pointer
  // --------------------------------------------------
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = prio_q;
    for (int unsigned k = 0; k < NrCommitPorts; k++) begin
      idx = (int'(prio_q) + k) % NrCommitPorts;
      if (!grant_valid && !empty_i[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = port_idx_t'(idx);
      end
    end
  end

  // One pop per cycle to the granted queue only
  always_comb begin
    pop_o = '0;
    if (grant_valid) begin
      pop_o[grant_idx] = 1'b1;
    end
  end

  // Port after the granted one gets first pick next time
  always_comb begin
    prio_d = prio_q;
    if (grant_valid) begin
      if (grant_idx == PortIdxWidth'(NrCommitPorts - 1)) begin
        prio_d = '0;
      end else begin
        prio_d = grant_idx + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;
      pc_valid_q <= 1'b0;
    end else begin
      prio_q     <= prio_d;
      pc_valid_q <= grant_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      pc_q   <= head_i[grant_idx];
      port_q <= grant_idx;
    end
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;
  assign pc_port_o  = port_q;

endmodule

// File: src/pc_queue.sv
// Retired PC queue
`timescale 1ns/1ns

module pc_queue import isa_pkg::*, trace_pkg::*; #(
  parameter int unsigned Depth = PcQueueDepth
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  commit_entry_t commit_i,
  input  logic          ack_i,
  input  logic          pop_i,
  output vaddr_t        head_o,
  output logic          empty_o,
  output logic          overflow_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;

  vaddr_t          mem_q [Depth];
  ptr_t            rd_ptr_q;
  ptr_t            wr_ptr_q;
  logic [PtrWidth:0] count_q;
  logic            overflow_q;
  logic            push_req;
  logic            full;
  logic            push;
  logic            pop;

  // Trapped instructions do not retire a PC
  assign push_req = ack_i & ~commit_i.ex.valid;
  assign full     = (count_q == (PtrWidth + 1)'(Depth));
  assign empty_o  = (count_q == '0);
  assign push     = push_req & ~full;
  assign pop      = pop_i & ~empty_o;

  // --------------------------------------------------
  // Pointers and fill count
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky until reset
      if (push_req && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= commit_i.pc;
    end
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// File: src/trace_encoder.sv
// Commit trace encoder
`timescale 1ns/1ns

module trace_encoder import isa_pkg::*, trace_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  commit_entry_t [NrCommitPorts-1:0]  commit_instr_i,
  input  logic          [NrCommitPorts-1:0]  commit_ack_i,
  input  priv_lvl_t                          priv_lvl_i,
  input  logic                               debug_mode_i,
  output trace_entry_t  [NrCommitPorts-1:0]  trace_o
);

  trace_mode_t                       mode;
  trace_entry_t [NrCommitPorts-1:0]  record_d;
  trace_entry_t [NrCommitPorts-1:0]  record_q;
  logic         [NrCommitPorts-1:0]  valid_q;
  logic         [NrCommitPorts-1:0]  exception_q;
  logic         [NrCommitPorts-1:0]  interrupt_q;

  // Debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = ModeD;
    end else begin
      case (priv_lvl_i)
        PrivU:   mode = ModeU;
        PrivS:   mode = ModeS;
        default: mode = ModeM;
      endcase
    end
  end

  // --------------------------------------------------
  // Classification per port
  // --------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      record_d[i].valid     = commit_ack_i[i] & ~commit_instr_i[i].ex.valid;
      record_d[i].exception = commit_ack_i[i] & commit_instr_i[i].ex.valid
                              & ~commit_instr_i[i].ex.cause[CauseIrqBit];
      record_d[i].interrupt = commit_ack_i[i] & commit_instr_i[i].ex.valid
                              & commit_instr_i[i].ex.cause[CauseIrqBit];
      record_d[i].iaddr     = commit_instr_i[i].pc;
      // tval holds the instruction word on a normal retirement
      record_d[i].insn      = commit_instr_i[i].ex.tval[InstrWidth-1:0];
      record_d[i].mode      = mode;
      record_d[i].cause     = commit_instr_i[i].ex.cause;
      record_d[i].tval      = commit_instr_i[i].ex.tval[InstrWidth-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      exception_q <= '0;
      interrupt_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NrCommitPorts; i++) begin
        valid_q[i]     <= record_d[i].valid;
        exception_q[i] <= record_d[i].exception;
        interrupt_q[i] <= record_d[i].interrupt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    record_q <= record_d;
  end

  // Flags come from the reset registers
  always_comb begin
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      trace_o[i]           = record_q[i];
      trace_o[i].valid     = valid_q[i];
      trace_o[i].exception = exception_q[i];
      trace_o[i].interrupt = interrupt_q[i];
    end
  end

endmodule

// File: src/trace_pkg.sv
// Commit trace definitions
package trace_pkg;

  import isa_pkg::*;

  // --------------------------------------------------
  // Commit side configuration
  // --------------------------------------------------
  localparam int unsigned NrCommitPorts = 2;
  // Entries per PC queue
  localparam int unsigned PcQueueDepth  = 16;
  localparam int unsigned PortIdxWidth  = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // Retiring instruction as seen at a commit port
  typedef struct packed {
    vaddr_t     pc;
    exception_t ex;
  } commit_entry_t;

  // --------------------------------------------------
  // Trace record
  // --------------------------------------------------
  // U, S and M follow the privilege encoding
  typedef enum logic [2:0] {
    ModeU = 3'd0,
    ModeS = 3'd1,
    ModeM = 3'd3,
    ModeD = 3'd4
  } trace_mode_t;

  typedef struct packed {
    logic                  valid;
    logic                  exception;
    logic                  interrupt;
    vaddr_t                iaddr;
    logic [InstrWidth-1:0] insn;
    trace_mode_t           mode;
    xlen_t                 cause;
    logic [InstrWidth-1:0] tval;
  } trace_entry_t;

endpackage

// File: src/isa_pkg.sv
// ISA-level definitions
package isa_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  // Data width
  localparam int unsigned Xlen       = 64;
  // Virtual address width
  localparam int unsigned Vlen       = 64;
  // Instruction word width
  localparam int unsigned InstrWidth = 32;

  typedef logic [Xlen-1:0] xlen_t;
  typedef logic [Vlen-1:0] vaddr_t;

  // --------------------------------------------------
  // Privilege levels
  // --------------------------------------------------
  // Encoding 2 is reserved
  typedef enum logic [1:0] {
    PrivU = 2'b00,
    PrivS = 2'b01,
    PrivM = 2'b11
  } priv_lvl_t;

  // --------------------------------------------------
  // Trap cause layout
  // --------------------------------------------------
  // MSB of the cause tells interrupts from exceptions
  localparam int unsigned CauseIrqBit = 63;

  typedef struct packed {
    logic  valid;
    xlen_t cause;
    // Faulting address or instruction word
    xlen_t tval;
  } exception_t;

endpackage
